// ==== verilog/reg_status_pkg.sv ====
// shared sizes for the register status block
// covers the architectural register file, the dispatch group and the
// compact reorder buffer
`default_nettype none

package reg_status_pkg;

	// architectural registers and the width of a register index
	localparam int num_regs = 8;
	localparam int reg_bits = 3;

	// dispatch slots per cycle, which is also the number of commit ports
	localparam int num_slots = 3;

	// reorder buffer depth and the width of a rob id
	// the wrap bit of the head and tail pointers stays inside the rob control
	localparam int rob_entries = 8;
	localparam int rob_bits = 3;

endpackage

`default_nettype wire

// ==== verilog/rob_control.sv ====
// reorder buffer bookkeeping for the register status block
// holds head and tail pointers and the per-entry valid, done, rfw and target
// gives ids to the dispatch group, commits up to three entries in order
// and rewinds the tail on a branch miss
`timescale 1ns/1ns
`default_nettype none

module rob_control (
	input  wire clk,
	input  wire rst,
	input  wire [reg_status_pkg::num_slots-1:0] slot_v,
	input  wire [reg_status_pkg::num_slots-1:0] slot_rfw,
	input  wire [reg_status_pkg::reg_bits-1:0] slot_rd0, slot_rd1, slot_rd2,
	input  wire done_v,
	input  wire [reg_status_pkg::rob_bits-1:0] done_id,
	input  wire branchmiss,
	input  wire [reg_status_pkg::rob_bits-1:0] miss_id,
	output logic dispatch_ready,
	output logic [reg_status_pkg::rob_bits:0] rob_count,
	output logic [reg_status_pkg::num_slots-1:0] alloc_v,
	output logic [reg_status_pkg::rob_bits-1:0] alloc_id0, alloc_id1, alloc_id2,
	output logic commit0_v, commit1_v, commit2_v,
	output logic [reg_status_pkg::rob_bits-1:0] commit0_id, commit1_id, commit2_id,
	output logic [reg_status_pkg::reg_bits-1:0] commit0_tgt, commit1_tgt, commit2_tgt,
	output logic [reg_status_pkg::rob_entries-1:0] live_mask,
	output logic [reg_status_pkg::rob_entries-1:0] rob_rfw,
	output logic [reg_status_pkg::rob_entries-1:0][reg_status_pkg::reg_bits-1:0] rob_tgt
);

	// pointers carry one wrap bit above the id so a full rob differs from empty
	logic [reg_status_pkg::rob_bits:0] head;
	logic [reg_status_pkg::rob_bits:0] tail;
	logic [reg_status_pkg::rob_bits:0] miss_tail;
	logic [reg_status_pkg::rob_bits:0] n_commit;
	logic [reg_status_pkg::rob_bits:0] n_alloc;
	logic [reg_status_pkg::rob_bits-1:0] head_id;
	logic [reg_status_pkg::rob_bits-1:0] miss_off;

	// per-entry bookkeeping
	logic [reg_status_pkg::rob_entries-1:0] ent_v;
	logic [reg_status_pkg::rob_entries-1:0] ent_done;
	logic [reg_status_pkg::rob_entries-1:0] ent_rfw;
	logic [reg_status_pkg::rob_entries-1:0][reg_status_pkg::reg_bits-1:0] ent_tgt;

	// per-slot views of the dispatch group and the commit window
	logic accept;
	logic all_done;
	logic [reg_status_pkg::rob_bits-1:0] slot_id [reg_status_pkg::num_slots];
	logic [reg_status_pkg::reg_bits-1:0] slot_rd [reg_status_pkg::num_slots];
	logic [reg_status_pkg::rob_bits-1:0] hid [reg_status_pkg::num_slots];
	logic [reg_status_pkg::num_slots-1:0] ok;
	logic [reg_status_pkg::num_slots-1:0] run;

	assign head_id = head[reg_status_pkg::rob_bits-1:0];
	assign rob_count = tail - head;
	assign rob_rfw = ent_rfw;
	assign rob_tgt = ent_tgt;
	assign slot_rd[0] = slot_rd0;
	assign slot_rd[1] = slot_rd1;
	assign slot_rd[2] = slot_rd2;

	// ========================================================================
	// dispatch side
	// ========================================================================

	// a whole group of three must fit, so the source never has to split it
	assign dispatch_ready = rob_count <=
		(reg_status_pkg::rob_bits + 1)'(reg_status_pkg::rob_entries - reg_status_pkg::num_slots);

	always_comb begin
		// a miss cycle never takes new work since the tail is being rewound
		accept = dispatch_ready && !branchmiss;
		alloc_v = slot_v & {reg_status_pkg::num_slots{accept}};
		n_alloc = '0;
		// valid slots take consecutive ids from the tail in slot order
		for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
			slot_id[k] = tail[reg_status_pkg::rob_bits-1:0] +
				n_alloc[reg_status_pkg::rob_bits-1:0];
			n_alloc = n_alloc + (reg_status_pkg::rob_bits + 1)'(alloc_v[k]);
		end
	end

	assign alloc_id0 = slot_id[0];
	assign alloc_id1 = slot_id[1];
	assign alloc_id2 = slot_id[2];

	// ========================================================================
	// branch miss and in-order commit
	// ========================================================================

	always_comb begin
		// distance of the branch from the head, used as its age
		miss_off = miss_id - head_id;
		for (int i = 0; i < reg_status_pkg::rob_entries; i++) begin
			live_mask[i] = ent_v[i] &&
				((reg_status_pkg::rob_bits'(i) - head_id) <= miss_off);
		end
		// the branch itself survives, so the tail lands one past it
		miss_tail = head + (reg_status_pkg::rob_bits + 1)'(miss_off) +
			(reg_status_pkg::rob_bits + 1)'(1);
	end

	always_comb begin
		all_done = 1'b1;
		n_commit = '0;
		for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
			hid[k] = head_id + reg_status_pkg::rob_bits'(k);
			// an entry squashed by a miss in this cycle must not retire
			ok[k] = ent_v[hid[k]] && ent_done[hid[k]] &&
				(!branchmiss || live_mask[hid[k]]);
			// the run stops at the first entry that is not done yet
			all_done = all_done && ok[k];
			run[k] = all_done;
			n_commit = n_commit + (reg_status_pkg::rob_bits + 1)'(all_done);
		end
	end

	// entries that write no register retire without raising commit_v
	// the ids are driven even when idle, commit0_id is always the head
	assign commit0_v = run[0] && ent_rfw[hid[0]];
	assign commit1_v = run[1] && ent_rfw[hid[1]];
	assign commit2_v = run[2] && ent_rfw[hid[2]];
	assign commit0_id = hid[0];
	assign commit1_id = hid[1];
	assign commit2_id = hid[2];
	assign commit0_tgt = ent_tgt[hid[0]];
	assign commit1_tgt = ent_tgt[hid[1]];
	assign commit2_tgt = ent_tgt[hid[2]];

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			ent_v <= '0;
			ent_done <= '0;
		end else begin
			head <= head + n_commit;
			if (branchmiss)
				tail <= miss_tail;
			else
				tail <= tail + n_alloc;
			// completion of an entry that was squashed earlier is dropped
			if (done_v && ent_v[done_id])
				ent_done[done_id] <= 1'b1;
			if (branchmiss)
				ent_v <= ent_v & live_mask;
			for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
				if (run[k])
					ent_v[hid[k]] <= 1'b0;
			end
			// new entries are free slots at the tail, never in the commit run
			for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
				if (alloc_v[k]) begin
					ent_v[slot_id[k]] <= 1'b1;
					ent_done[slot_id[k]] <= 1'b0;
				end
			end
		end
	end

	// target fields only mean something while the entry is valid
	always_ff @(posedge clk) begin
		for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
			if (alloc_v[k]) begin
				ent_rfw[slot_id[k]] <= slot_rfw[k];
				ent_tgt[slot_id[k]] <= slot_rd[k];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rollback_scan.sv ====
// branch miss rollback of the producer map
// finds for each register whether a surviving rob entry writes it
// and the id of the youngest such survivor
`timescale 1ns/1ns
`default_nettype none

module rollback_scan (
	input  wire [reg_status_pkg::rob_entries-1:0] live_mask,
	input  wire [reg_status_pkg::rob_entries-1:0] rob_rfw,
	input  wire [reg_status_pkg::rob_entries-1:0][reg_status_pkg::reg_bits-1:0] rob_tgt,
	input  wire [reg_status_pkg::rob_bits-1:0] head_id,
	output logic [reg_status_pkg::num_regs-1:0] livetarget,
	output logic [reg_status_pkg::rob_bits-1:0] restore_id0, restore_id1,
	output logic [reg_status_pkg::rob_bits-1:0] restore_id2, restore_id3,
	output logic [reg_status_pkg::rob_bits-1:0] restore_id4, restore_id5,
	output logic [reg_status_pkg::rob_bits-1:0] restore_id6, restore_id7
);

	logic [reg_status_pkg::rob_bits-1:0] restore_tab [reg_status_pkg::num_regs];

	// walk from the head toward the tail so that a later hit overwrites an
	// earlier one, leaving the youngest survivor for each register
	always_comb begin
		logic [reg_status_pkg::rob_bits-1:0] idx;
		livetarget = '0;
		for (int r = 0; r < reg_status_pkg::num_regs; r++) begin
			restore_tab[r] = '0;
		end
		for (int k = 0; k < reg_status_pkg::rob_entries; k++) begin
			idx = head_id + reg_status_pkg::rob_bits'(k);
			// squashed and non-writing entries leave the map alone
			if (live_mask[idx] && rob_rfw[idx]) begin
				livetarget[rob_tgt[idx]] = 1'b1;
				restore_tab[rob_tgt[idx]] = idx;
			end
		end
	end

	assign restore_id0 = restore_tab[0];
	assign restore_id1 = restore_tab[1];
	assign restore_id2 = restore_tab[2];
	assign restore_id3 = restore_tab[3];
	assign restore_id4 = restore_tab[4];
	assign restore_id5 = restore_tab[5];
	assign restore_id6 = restore_tab[6];
	assign restore_id7 = restore_tab[7];

endmodule

`default_nettype wire

// ==== verilog/producer_map.sv ====
// newest producer table, one rob id per architectural register
// written at dispatch with the later slot winning, restored on a branch miss
`timescale 1ns/1ns
`default_nettype none

module producer_map (
	input  wire clk,
	input  wire rst,
	input  wire [reg_status_pkg::num_slots-1:0] alloc_v,
	input  wire [reg_status_pkg::rob_bits-1:0] alloc_id0, alloc_id1, alloc_id2,
	input  wire [reg_status_pkg::num_slots-1:0] slot_rfw,
	input  wire [reg_status_pkg::reg_bits-1:0] slot_rd0, slot_rd1, slot_rd2,
	input  wire branchmiss,
	input  wire [reg_status_pkg::num_regs-1:0] livetarget,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id0, restore_id1,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id2, restore_id3,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id4, restore_id5,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id6, restore_id7,
	output logic [reg_status_pkg::rob_bits-1:0] src_id0, src_id1, src_id2, src_id3,
	output logic [reg_status_pkg::rob_bits-1:0] src_id4, src_id5, src_id6, src_id7
);

	logic [reg_status_pkg::rob_bits-1:0] src_tab [reg_status_pkg::num_regs];
	logic [reg_status_pkg::rob_bits-1:0] restore_tab [reg_status_pkg::num_regs];
	logic [reg_status_pkg::rob_bits-1:0] slot_id [reg_status_pkg::num_slots];
	logic [reg_status_pkg::reg_bits-1:0] slot_rd [reg_status_pkg::num_slots];

	assign slot_id = '{alloc_id0, alloc_id1, alloc_id2};
	assign slot_rd = '{slot_rd0, slot_rd1, slot_rd2};
	assign restore_tab = '{restore_id0, restore_id1, restore_id2, restore_id3,
		restore_id4, restore_id5, restore_id6, restore_id7};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < reg_status_pkg::num_regs; r++) begin
				src_tab[r] <= '0;
			end
		end else if (branchmiss) begin
			// registers with no survivor keep a stale id, their valid bit is set
			for (int r = 0; r < reg_status_pkg::num_regs; r++) begin
				if (livetarget[r])
					src_tab[r] <= restore_tab[r];
			end
		end else begin
			// slots run oldest first, so the last write to a register wins
			for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
				if (alloc_v[k] && slot_rfw[k])
					src_tab[slot_rd[k]] <= slot_id[k];
			end
		end
	end

	assign src_id0 = src_tab[0];
	assign src_id1 = src_tab[1];
	assign src_id2 = src_tab[2];
	assign src_id3 = src_tab[3];
	assign src_id4 = src_tab[4];
	assign src_id5 = src_tab[5];
	assign src_id6 = src_tab[6];
	assign src_id7 = src_tab[7];

endmodule

`default_nettype wire

// ==== verilog/reg_valid_track.sv ====
// architectural register valid bits
// rf_v is the registered state, reg_is_valid its value after the next edge
// register 0 is hard-wired valid
`timescale 1ns/1ns
`default_nettype none

module reg_valid_track (
	input  wire clk,
	input  wire rst,
	input  wire [reg_status_pkg::num_slots-1:0] alloc_v,
	input  wire [reg_status_pkg::num_slots-1:0] slot_rfw,
	input  wire [reg_status_pkg::reg_bits-1:0] slot_rd0, slot_rd1, slot_rd2,
	input  wire commit0_v, commit1_v, commit2_v,
	input  wire [reg_status_pkg::rob_bits-1:0] commit0_id, commit1_id, commit2_id,
	input  wire [reg_status_pkg::reg_bits-1:0] commit0_tgt, commit1_tgt, commit2_tgt,
	input  wire branchmiss,
	input  wire [reg_status_pkg::num_regs-1:0] livetarget,
	input  wire [reg_status_pkg::rob_bits-1:0] src_id0, src_id1, src_id2, src_id3,
	input  wire [reg_status_pkg::rob_bits-1:0] src_id4, src_id5, src_id6, src_id7,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id0, restore_id1,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id2, restore_id3,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id4, restore_id5,
	input  wire [reg_status_pkg::rob_bits-1:0] restore_id6, restore_id7,
	output logic [reg_status_pkg::num_regs-1:0] rf_v,
	output logic [reg_status_pkg::num_regs-1:0] reg_is_valid
);

	logic [reg_status_pkg::rob_bits-1:0] src_tab [reg_status_pkg::num_regs];
	logic [reg_status_pkg::rob_bits-1:0] restore_tab [reg_status_pkg::num_regs];
	logic [reg_status_pkg::num_slots-1:0] cv;
	logic [reg_status_pkg::rob_bits-1:0] cid [reg_status_pkg::num_slots];
	logic [reg_status_pkg::reg_bits-1:0] ctgt [reg_status_pkg::num_slots];
	logic [reg_status_pkg::reg_bits-1:0] slot_rd [reg_status_pkg::num_slots];
	logic [reg_status_pkg::num_regs-1:0] nxt;

	assign src_tab = '{src_id0, src_id1, src_id2, src_id3,
		src_id4, src_id5, src_id6, src_id7};
	assign restore_tab = '{restore_id0, restore_id1, restore_id2, restore_id3,
		restore_id4, restore_id5, restore_id6, restore_id7};
	assign cv = {commit2_v, commit1_v, commit0_v};
	assign cid = '{commit0_id, commit1_id, commit2_id};
	assign ctgt = '{commit0_tgt, commit1_tgt, commit2_tgt};
	assign slot_rd = '{slot_rd0, slot_rd1, slot_rd2};

	// ========================================================================
	// look-ahead value, read by the read-through register file
	// ========================================================================

	always_comb begin
		logic [reg_status_pkg::rob_bits-1:0] prod;
		nxt = rf_v;
		// a register whose producers were all squashed holds its final value
		if (branchmiss)
			nxt = nxt | ~livetarget;
		for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
			// in a miss cycle the commit is checked against the restored producer
			if (branchmiss && livetarget[ctgt[k]])
				prod = restore_tab[ctgt[k]];
			else
				prod = src_tab[ctgt[k]];
			// only the newest producer may validate, an older one leaves it pending
			if (cv[k] && prod == cid[k])
				nxt[ctgt[k]] = 1'b1;
		end
		nxt[0] = 1'b1;
	end

	assign reg_is_valid = nxt;

	// ========================================================================
	// registered valid bits
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rf_v <= '1;
		end else begin
			rf_v <= nxt;
			// dispatch comes after commit so a new writer of the same register wins
			if (!branchmiss) begin
				for (int k = 0; k < reg_status_pkg::num_slots; k++) begin
					if (alloc_v[k] && slot_rfw[k] && slot_rd[k] != '0)
						rf_v[slot_rd[k]] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reg_status_top.sv ====
// register status subsystem of a three-wide out-of-order core
// ties the rob control, the rollback scan, the producer map and the
// register valid tracking to the outside ports
`timescale 1ns/1ns
`default_nettype none

module reg_status_top (
	input  wire clk,
	input  wire rst,
	input  wire [reg_status_pkg::num_slots-1:0] slot_v,
	input  wire [reg_status_pkg::num_slots-1:0] slot_rfw,
	input  wire [reg_status_pkg::reg_bits-1:0] slot_rd0, slot_rd1, slot_rd2,
	input  wire done_v,
	input  wire [reg_status_pkg::rob_bits-1:0] done_id,
	input  wire branchmiss,
	input  wire [reg_status_pkg::rob_bits-1:0] miss_id,
	output logic dispatch_ready,
	output logic [reg_status_pkg::num_regs-1:0] rf_v,
	output logic [reg_status_pkg::num_regs-1:0] reg_is_valid,
	output logic [reg_status_pkg::rob_bits:0] rob_count
);

	// dispatch group after acceptance
	wire [reg_status_pkg::num_slots-1:0] alloc_v;
	wire [reg_status_pkg::rob_bits-1:0] alloc_id0, alloc_id1, alloc_id2;

	// commit ports, commit0_id doubles as the head id for the rollback scan
	wire commit0_v, commit1_v, commit2_v;
	wire [reg_status_pkg::rob_bits-1:0] commit0_id, commit1_id, commit2_id;
	wire [reg_status_pkg::reg_bits-1:0] commit0_tgt, commit1_tgt, commit2_tgt;

	// rob contents seen by the rollback scan
	wire [reg_status_pkg::rob_entries-1:0] live_mask;
	wire [reg_status_pkg::rob_entries-1:0] rob_rfw;
	wire [reg_status_pkg::rob_entries-1:0][reg_status_pkg::reg_bits-1:0] rob_tgt;

	// rollback results and the current producer ids
	wire [reg_status_pkg::num_regs-1:0] livetarget;
	wire [reg_status_pkg::rob_bits-1:0] restore_id0, restore_id1, restore_id2, restore_id3;
	wire [reg_status_pkg::rob_bits-1:0] restore_id4, restore_id5, restore_id6, restore_id7;
	wire [reg_status_pkg::rob_bits-1:0] src_id0, src_id1, src_id2, src_id3;
	wire [reg_status_pkg::rob_bits-1:0] src_id4, src_id5, src_id6, src_id7;

	rob_control i_rob_control (
		.clk, .rst, .slot_v, .slot_rfw, .slot_rd0, .slot_rd1, .slot_rd2,
		.done_v, .done_id, .branchmiss, .miss_id,
		.dispatch_ready, .rob_count, .alloc_v, .alloc_id0, .alloc_id1, .alloc_id2,
		.commit0_v, .commit1_v, .commit2_v, .commit0_id, .commit1_id, .commit2_id,
		.commit0_tgt, .commit1_tgt, .commit2_tgt, .live_mask, .rob_rfw, .rob_tgt
	);

	rollback_scan i_rollback_scan (
		.live_mask, .rob_rfw, .rob_tgt, .head_id(commit0_id), .livetarget,
		.restore_id0, .restore_id1, .restore_id2, .restore_id3,
		.restore_id4, .restore_id5, .restore_id6, .restore_id7
	);

	producer_map i_producer_map (
		.clk, .rst, .alloc_v, .alloc_id0, .alloc_id1, .alloc_id2,
		.slot_rfw, .slot_rd0, .slot_rd1, .slot_rd2, .branchmiss, .livetarget,
		.restore_id0, .restore_id1, .restore_id2, .restore_id3,
		.restore_id4, .restore_id5, .restore_id6, .restore_id7,
		.src_id0, .src_id1, .src_id2, .src_id3,
		.src_id4, .src_id5, .src_id6, .src_id7
	);

	reg_valid_track i_reg_valid_track (
		.clk, .rst, .alloc_v, .slot_rfw, .slot_rd0, .slot_rd1, .slot_rd2,
		.commit0_v, .commit1_v, .commit2_v, .commit0_id, .commit1_id, .commit2_id,
		.commit0_tgt, .commit1_tgt, .commit2_tgt, .branchmiss, .livetarget,
		.src_id0, .src_id1, .src_id2, .src_id3,
		.src_id4, .src_id5, .src_id6, .src_id7,
		.restore_id0, .restore_id1, .restore_id2, .restore_id3,
		.restore_id4, .restore_id5, .restore_id6, .restore_id7,
		.rf_v, .reg_is_valid
	);

endmodule

`default_nettype wire

// ==== dv/tb_reg_status.sv ====
// directed testbench for the register status block
// a reference model of the rob gives the expected rf_v, reg_is_valid,
// rob_count and dispatch_ready on every cycle
// the directed tests add targeted checks on top of the model
`timescale 1ns/1ns
`default_nettype none

module tb_reg_status;

	logic clk = 1'b0;
	logic rst;
	logic [reg_status_pkg::num_slots-1:0] slot_v;
	logic [reg_status_pkg::num_slots-1:0] slot_rfw;
	logic [reg_status_pkg::reg_bits-1:0] slot_rd0, slot_rd1, slot_rd2;
	logic done_v;
	logic [reg_status_pkg::rob_bits-1:0] done_id;
	logic branchmiss;
	logic [reg_status_pkg::rob_bits-1:0] miss_id;
	wire dispatch_ready;
	wire [reg_status_pkg::num_regs-1:0] rf_v;
	wire [reg_status_pkg::num_regs-1:0] reg_is_valid;
	wire [reg_status_pkg::rob_bits:0] rob_count;

	// the model rob keeps one queue per field with the oldest entry first
	logic [2:0] q_id [$];
	logic [2:0] q_tgt [$];
	bit q_rfw [$];
	bit q_done [$];
	logic [2:0] m_tail;
	// whether the model took the group driven in the last cycle
	bit accepted;
	int errors;
	int tests;
	logic [31:0] rnd;

	reg_status_top i_reg_status_top (.*);

	always #50 clk = ~clk;

	// ========================================================================
	// reference model
	// ========================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// a register is valid when no entry in positions [first, last) writes it
	function automatic logic [7:0] valid_bits(input int first, input int last);
		logic [7:0] v;
		v = '1;
		for (int i = first; i < last; i++) begin
			if (q_rfw[i])
				v[q_tgt[i]] = 1'b0;
		end
		v[0] = 1'b1;
		return v;
	endfunction

	// number of entries that survive a miss including the branch itself
	function automatic int survivors(input bit bm, input logic [2:0] mid);
		int n;
		n = q_id.size();
		if (bm) begin
			for (int i = 0; i < q_id.size(); i++) begin
				if (q_id[i] == mid)
					n = i + 1;
			end
		end
		return n;
	endfunction

	// count of done entries from the head with at most one per commit port
	function automatic int commit_run(input int keep);
		int n;
		n = 0;
		while (n < 3 && n < keep && q_done[n])
			n++;
		return n;
	endfunction

	// a group may enter only while at least three rob entries are free
	function automatic bit group_fits();
		return reg_status_pkg::rob_entries - q_id.size() >= 3;
	endfunction

	function automatic int first_pending();
		int idx;
		idx = -1;
		for (int i = q_id.size() - 1; i >= 0; i--) begin
			if (!q_done[i])
				idx = i;
		end
		return idx;
	endfunction

	function automatic void drop_entry(input int i);
		q_id.delete(i);
		q_tgt.delete(i);
		q_rfw.delete(i);
		q_done.delete(i);
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// drives one cycle of inputs, checks the outputs, then steps the model
	task automatic drive_cycle(input logic [2:0] sv, input logic [2:0] rfw,
			input logic [2:0] rd0, input logic [2:0] rd1, input logic [2:0] rd2,
			input bit dv, input logic [2:0] did, input bit bm, input logic [2:0] mid);
		int keep;
		int run;
		logic [2:0] rd [3];
		@(posedge clk);
		slot_v <= sv;
		slot_rfw <= rfw;
		slot_rd0 <= rd0;
		slot_rd1 <= rd1;
		slot_rd2 <= rd2;
		done_v <= dv;
		done_id <= did;
		branchmiss <= bm;
		miss_id <= mid;
		// outputs and the look-ahead have settled by the falling edge
		@(negedge clk);
		keep = survivors(bm, mid);
		run = commit_run(keep);
		check("rf_v", 32'(rf_v), 32'(valid_bits(0, q_id.size())));
		check("reg_is_valid", 32'(reg_is_valid), 32'(valid_bits(run, keep)));
		check("rob_count", 32'(rob_count), 32'(q_id.size()));
		check("dispatch_ready", 32'(dispatch_ready), 32'(group_fits()));
		// the model now takes the edge that samples these inputs
		accepted = group_fits() && !bm;
		for (int i = q_id.size() - 1; i >= keep; i--)
			drop_entry(i);
		repeat (run) drop_entry(0);
		if (dv) begin
			for (int i = 0; i < q_id.size(); i++) begin
				if (q_id[i] == did)
					q_done[i] = 1'b1;
			end
		end
		if (bm)
			m_tail = mid + 3'd1;
		rd[0] = rd0;
		rd[1] = rd1;
		rd[2] = rd2;
		if (accepted) begin
			for (int k = 0; k < 3; k++) begin
				if (sv[k]) begin
					q_id.push_back(m_tail);
					q_tgt.push_back(rd[k]);
					q_rfw.push_back(rfw[k]);
					q_done.push_back(1'b0);
					m_tail = m_tail + 3'd1;
				end
			end
		end
	endtask

	// ========================================================================
	// stimulus helpers
	// ========================================================================

	task automatic idle();
		drive_cycle(3'b000, 3'b000, 3'd0, 3'd0, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0);
	endtask

	task automatic complete(input logic [2:0] id);
		drive_cycle(3'b000, 3'b000, 3'd0, 3'd0, 3'd0, 1'b1, id, 1'b0, 3'd0);
	endtask

	// the source holds the group until the rob takes it
	task automatic dispatch(input logic [2:0] sv, input logic [2:0] rfw,
			input logic [2:0] rd0, input logic [2:0] rd1, input logic [2:0] rd2);
		int n;
		n = 0;
		accepted = 1'b0;
		while (!accepted && n < 20) begin
			drive_cycle(sv, rfw, rd0, rd1, rd2, 1'b0, 3'd0, 1'b0, 3'd0);
			n++;
		end
		if (!accepted) begin
			errors++;
			$display("timeout: a dispatch group was never accepted");
		end
	endtask

	task automatic wait_valid(input int r);
		int n;
		n = 0;
		while (!rf_v[r] && n < 20) begin
			idle();
			n++;
		end
		if (!rf_v[r]) begin
			errors++;
			$display("timeout: register %0d never became valid", r);
		end
	endtask

	// completes whatever is still in flight until the rob is empty
	task automatic drain();
		int n;
		int i;
		n = 0;
		while (rob_count != '0 && n < 40) begin
			i = first_pending();
			if (i >= 0)
				complete(q_id[i]);
			else
				idle();
			n++;
		end
		if (rob_count != '0) begin
			errors++;
			$display("timeout: the rob did not drain");
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("%s: passed", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================

	task automatic reset_defaults();
		int e0;
		e0 = errors;
		idle();
		check("rf_v after reset", 32'(rf_v), 32'hff);
		check("reg_is_valid after reset", 32'(reg_is_valid), 32'hff);
		check("dispatch_ready after reset", 32'(dispatch_ready), 32'd1);
		check("rob_count after reset", 32'(rob_count), 32'd0);
		report_test("reset", e0);
	endtask

	task automatic dispatch_clears();
		int e0;
		e0 = errors;
		// slot 1 writes nothing and slot 2 targets the hard-wired register
		dispatch(3'b111, 3'b101, 3'd3, 3'd4, 3'd0);
		idle();
		check("rf_v[3] after dispatch", 32'(rf_v[3]), 32'd0);
		check("rf_v[4] without rfw", 32'(rf_v[4]), 32'd1);
		check("rf_v[0] after dispatch", 32'(rf_v[0]), 32'd1);
		check("rob_count after dispatch", 32'(rob_count), 32'd3);
		drain();
		report_test("dispatch", e0);
	endtask

	task automatic in_order_commit();
		int e0;
		logic [2:0] a, b, c;
		e0 = errors;
		dispatch(3'b111, 3'b111, 3'd1, 3'd2, 3'd5);
		a = q_id[0];
		b = q_id[1];
		c = q_id[2];
		complete(c);
		complete(b);
		repeat (3) idle();
		check("rf_v[5] behind an unfinished entry", 32'(rf_v[5]), 32'd0);
		check("rf_v[2] behind an unfinished entry", 32'(rf_v[2]), 32'd0);
		complete(a);
		idle();
		// in the commit cycle the look-ahead leads rf_v by one edge
		check("reg_is_valid[1] in commit cycle", 32'(reg_is_valid[1]), 32'd1);
		check("rf_v[1] in commit cycle", 32'(rf_v[1]), 32'd0);
		wait_valid(5);
		drain();
		report_test("in-order commit", e0);
	endtask

	task automatic overwrite();
		int e0;
		logic [2:0] a, b;
		e0 = errors;
		dispatch(3'b011, 3'b011, 3'd6, 3'd6, 3'd0);
		a = q_id[0];
		b = q_id[1];
		complete(a);
		repeat (3) idle();
		check("rob_count after older commit", 32'(rob_count), 32'd1);
		check("rf_v[6] after older commit", 32'(rf_v[6]), 32'd0);
		complete(b);
		wait_valid(6);
		drain();
		report_test("overwrite", e0);
	endtask

	task automatic branch_rollback();
		int e0;
		logic [2:0] a, b;
		e0 = errors;
		// slot 1 of the first group is the branch
		dispatch(3'b111, 3'b101, 3'd2, 3'd0, 3'd3);
		dispatch(3'b011, 3'b011, 3'd2, 3'd4, 3'd0);
		a = q_id[0];
		b = q_id[1];
		drive_cycle(3'b000, 3'b000, 3'd0, 3'd0, 3'd0, 1'b0, 3'd0, 1'b1, b);
		check("reg_is_valid[3] in miss cycle", 32'(reg_is_valid[3]), 32'd1);
		check("reg_is_valid[4] in miss cycle", 32'(reg_is_valid[4]), 32'd1);
		check("reg_is_valid[2] in miss cycle", 32'(reg_is_valid[2]), 32'd0);
		idle();
		check("rf_v[2] with a surviving producer", 32'(rf_v[2]), 32'd0);
		check("rob_count after miss", 32'(rob_count), 32'd2);
		complete(b);
		repeat (3) idle();
		check("rf_v[2] before its producer is done", 32'(rf_v[2]), 32'd0);
		complete(a);
		wait_valid(2);
		drain();
		report_test("branch miss", e0);
	endtask

	task automatic backpressure_random();
		int e0;
		int n;
		int i;
		int j;
		logic [2:0] sv, rfw, rd0, rd1, rd2, did, mid;
		bit dv;
		bit bm;
		bit pending;
		e0 = errors;
		dispatch(3'b111, 3'b111, 3'd1, 3'd2, 3'd3);
		dispatch(3'b111, 3'b111, 3'd4, 3'd5, 3'd6);
		idle();
		check("dispatch_ready with two free entries", 32'(dispatch_ready), 32'd0);
		// hold a third group while the oldest entries complete
		n = 0;
		accepted = 1'b0;
		while (!accepted && n < 20) begin
			i = first_pending();
			did = 3'd0;
			if (i >= 0)
				did = q_id[i];
			drive_cycle(3'b111, 3'b111, 3'd7, 3'd1, 3'd2, i >= 0, did, 1'b0, 3'd0);
			n++;
		end
		if (!accepted) begin
			errors++;
			$display("timeout: the held group was never accepted");
		end
		drain();
		// random dispatch, completion and miss streams where a refused group is held
		pending = 1'b0;
		for (int c = 0; c < 400; c++) begin
			if (!pending) begin
				rnd = xorshift(rnd);
				sv = rnd[2:0];
				rfw = rnd[5:3];
				rd0 = rnd[8:6];
				rd1 = rnd[11:9];
				rd2 = rnd[14:12];
				pending = 1'b1;
			end
			rnd = xorshift(rnd);
			dv = 1'b0;
			bm = 1'b0;
			did = 3'd0;
			mid = 3'd0;
			if (q_id.size() > 0) begin
				j = rnd[7:0] % q_id.size();
				dv = rnd[9:8] != 2'd0;
				did = q_id[j];
				j = rnd[23:16] % q_id.size();
				bm = rnd[15:12] == 4'd0;
				mid = q_id[j];
			end
			drive_cycle(sv, rfw, rd0, rd1, rd2, dv, did, bm, mid);
			if (accepted)
				pending = 1'b0;
		end
		drain();
		report_test("back-pressure and random traffic", e0);
	endtask

	initial begin
		rst = 1'b1;
		slot_v = '0;
		slot_rfw = '0;
		slot_rd0 = '0;
		slot_rd1 = '0;
		slot_rd2 = '0;
		done_v = 1'b0;
		done_id = '0;
		branchmiss = 1'b0;
		miss_id = '0;
		errors = 0;
		tests = 0;
		rnd = 32'h9ecc_9f80;
		m_tail = 3'd0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		reset_defaults();
		dispatch_clears();
		in_order_commit();
		overwrite();
		branch_rollback();
		backpressure_random();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/reg_status_pkg.sv
verilog/rob_control.sv
verilog/rollback_scan.sv
verilog/producer_map.sv
verilog/reg_valid_track.sv
verilog/reg_status_top.sv
dv/tb_reg_status.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= tb_reg_status
RTL_TOP    ?= reg_status_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ns
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0
FAIL_MSG   ?= Something failed
PASS_MSG   ?= Everything OK

RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP) -f $(FILELIST)
	$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
